//--- accel_consts.svh
`ifndef ACCEL_CONSTS_SVH
`define ACCEL_CONSTS_SVH

// iclk cycles per half sclk period
`define SCLK_HALF 2

// cycles after reset before the first transaction, short for simulation
`define POWERUP_CYCLES 200

// min csn high time between frames
`define CS_GAP 8

// x sample register, y and z follow
`define XDATA_ADDR 8'h08

`endif

//--- spi_pkg.sv
package spi_pkg;

    // spi controller states
    typedef enum logic [2:0] {
        st_power_up,    // sensor start-up wait
        st_idle,
        st_cs_setup,    // csn low, sclk not yet running
        st_shift,
        st_cs_hold,     // last fall to csn rise
        st_gap          // csn high between frames
    } spi_state_t;

    // first byte sent on mosi
    typedef enum logic [7:0] {
        instr_write = 8'h0A,
        instr_read  = 8'h0B
    } spi_instr_t;

endpackage

//--- accel_pkg.sv
package accel_pkg;

    // host command opcodes
    typedef enum logic [1:0] {
        op_read_xyz,    // burst read of x, y, z
        op_read_reg,
        op_write_reg
    } accel_op_t;

endpackage

//--- accel_cmd_decode.sv
`include "accel_consts.svh"

module accel_cmd_decode (
    input  logic                 iclk,
    input  logic                 reset,

    input  logic                 cmd_valid,
    input  accel_pkg::accel_op_t cmd_op,
    input  logic [7:0]           cmd_addr,
    input  logic [7:0]           cmd_wdata,
    output logic                 cmd_ready,

    output logic                 xfer_valid,
    input  logic                 xfer_ready,
    output spi_pkg::spi_instr_t  xfer_instr,
    output logic [7:0]           xfer_addr,
    output logic [7:0]           xfer_wdata,
    output logic [1:0]           xfer_nbytes
);
    import accel_pkg::*;
    import spi_pkg::*;

    logic full;     // one-entry command slot
    logic cmd_take;

    assign cmd_take   = cmd_valid && cmd_ready;
    assign cmd_ready  = !full;
    assign xfer_valid = full;

    always_ff @(posedge iclk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (cmd_take) begin
            full <= 1'b1;
        end else if (xfer_valid && xfer_ready) begin
            full <= 1'b0;   // master took it
        end
    end

    // map the command onto one spi frame
    always_ff @(posedge iclk) begin
        if (cmd_take) begin
            xfer_wdata <= cmd_wdata;
            case (cmd_op)
                op_read_xyz: begin
                    xfer_instr  <= instr_read;
                    xfer_addr   <= `XDATA_ADDR;
                    xfer_nbytes <= 2'd3;        // x, y, z in one burst
                end
                op_write_reg: begin
                    xfer_instr  <= instr_write;
                    xfer_addr   <= cmd_addr;
                    xfer_nbytes <= 2'd1;
                end
                default: begin                  // op_read_reg
                    xfer_instr  <= instr_read;
                    xfer_addr   <= cmd_addr;
                    xfer_nbytes <= 2'd1;
                end
            endcase
        end
    end

endmodule

//--- spi_master.sv
`include "accel_consts.svh"

module spi_master (
    input  logic                iclk,
    input  logic                reset,

    input  logic                xfer_valid,
    output logic                xfer_ready,
    input  spi_pkg::spi_instr_t xfer_instr,
    input  logic [7:0]          xfer_addr,
    input  logic [7:0]          xfer_wdata,
    input  logic [1:0]          xfer_nbytes,

    input  logic                rx_room,
    output logic                rx_valid,
    output logic [7:0]          rx_data,
    output logic                rx_last,

    output logic                sclk,
    output logic                csn,
    output logic                mosi,
    input  logic                miso
);
    import spi_pkg::*;

    spi_state_t  state;
    logic [15:0] wait_cnt;      // power-up and gap timer
    logic [7:0]  half_cnt;      // iclk cycles within one sclk phase
    logic [2:0]  bit_cnt;
    logic [2:0]  byte_cnt;      // 0 instr, 1 addr, then data
    logic [2:0]  last_byte;
    logic        is_read;
    logic [23:0] tx_sreg;       // instr, addr, write byte
    logic [7:0]  rx_sreg;
    logic        half_done;
    logic        rx_phase;
    logic        rise_now;

    assign half_done = (half_cnt == 8'(`SCLK_HALF - 1));
    assign rx_phase  = is_read && (byte_cnt >= 3'd2);
    // rising sclk edge inside the shift state
    assign rise_now  = (state == st_shift) && half_done && !sclk;

    // a read needs an empty result register, a write never does
    assign xfer_ready = (state == st_idle) && ((xfer_instr == instr_write) || rx_room);

    assign mosi    = tx_sreg[23];   // msb first, zeros shift in behind
    assign rx_data = rx_sreg;

    always_ff @(posedge iclk) begin
        if (reset) begin
            state    <= st_power_up;
            wait_cnt <= '0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            sclk     <= 1'b0;
            csn      <= 1'b1;
            tx_sreg  <= '0;
            rx_valid <= 1'b0;
            rx_last  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_last  <= 1'b0;
            case (state)
                st_power_up: begin
                    if (wait_cnt == 16'(`POWERUP_CYCLES - 1)) begin
                        state <= st_idle;
                    end else begin
                        wait_cnt <= wait_cnt + 16'd1;
                    end
                end
                st_idle: begin
                    if (xfer_valid && xfer_ready) begin
                        csn      <= 1'b0;
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        tx_sreg  <= {xfer_instr, xfer_addr,
                                     (xfer_instr == instr_write) ? xfer_wdata : 8'h00};
                        state    <= st_cs_setup;
                    end
                end
                st_cs_setup: begin
                    if (half_done) begin
                        sclk     <= 1'b1;   // first rise, instruction bit 7
                        half_cnt <= '0;
                        state    <= st_shift;
                    end else begin
                        half_cnt <= half_cnt + 8'd1;
                    end
                end
                st_shift: begin
                    if (!half_done) begin
                        half_cnt <= half_cnt + 8'd1;
                    end else if (sclk) begin
                        // falling edge, next bit goes out
                        half_cnt <= '0;
                        sclk     <= 1'b0;
                        tx_sreg  <= {tx_sreg[22:0], 1'b0};
                        if (bit_cnt == 3'd7) begin
                            bit_cnt <= '0;
                            if (byte_cnt == last_byte) begin
                                state <= st_cs_hold;
                            end else begin
                                byte_cnt <= byte_cnt + 3'd1;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end else begin
                        half_cnt <= '0;
                        sclk     <= 1'b1;
                        if (rx_phase && bit_cnt == 3'd7) begin
                            rx_valid <= 1'b1;   // eighth bit sampled with this rise
                            rx_last  <= (byte_cnt == last_byte);
                        end
                    end
                end
                st_cs_hold: begin
                    if (half_done) begin
                        csn      <= 1'b1;
                        wait_cnt <= '0;
                        state    <= st_gap;
                    end else begin
                        half_cnt <= half_cnt + 8'd1;
                    end
                end
                st_gap: begin
                    if (wait_cnt == 16'(`CS_GAP - 1)) begin
                        state <= st_idle;
                    end else begin
                        wait_cnt <= wait_cnt + 16'd1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // frame attributes and receive shifter
    always_ff @(posedge iclk) begin
        if (state == st_idle && xfer_valid && xfer_ready) begin
            is_read   <= (xfer_instr == instr_read);
            last_byte <= {1'b0, xfer_nbytes} + 3'd1;
        end
        if (rise_now && rx_phase) begin
            rx_sreg <= {rx_sreg[6:0], miso};
        end
    end

endmodule

//--- accel_sample_pack.sv
module accel_sample_pack (
    input  logic       iclk,
    input  logic       reset,

    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    input  logic       rx_last,
    output logic       rx_room,

    output logic       res_valid,
    input  logic       res_ready,
    output logic [7:0] res_x,
    output logic [7:0] res_y,
    output logic [7:0] res_z,
    output logic [1:0] res_nbytes
);
    logic       full;   // result register holds an untaken result
    logic [1:0] idx;    // next byte slot

    assign res_valid = full;
    assign rx_room   = !full;

    always_ff @(posedge iclk) begin
        if (reset) begin
            full <= 1'b0;
            idx  <= '0;
        end else begin
            if (rx_valid) begin
                idx <= rx_last ? 2'd0 : idx + 2'd1;
            end
            if (rx_valid && rx_last) begin
                full <= 1'b1;
            end else if (res_valid && res_ready) begin
                full <= 1'b0;
            end
        end
    end

    // byte placement, held until the host takes it
    always_ff @(posedge iclk) begin
        if (rx_valid) begin
            case (idx)
                2'd0: begin
                    res_x <= rx_data;
                    res_y <= 8'h00;     // cleared in case only one byte comes
                    res_z <= 8'h00;
                end
                2'd1:    res_y <= rx_data;
                default: res_z <= rx_data;
            endcase
            if (rx_last) begin
                res_nbytes <= idx + 2'd1;
            end
        end
    end

endmodule

//--- accel_reader_top.sv
module accel_reader_top (
    input  logic                 iclk,
    input  logic                 reset,

    input  logic                 cmd_valid,
    input  accel_pkg::accel_op_t cmd_op,
    input  logic [7:0]           cmd_addr,
    input  logic [7:0]           cmd_wdata,
    output logic                 cmd_ready,

    output logic                 res_valid,
    input  logic                 res_ready,
    output logic [7:0]           res_x,
    output logic [7:0]           res_y,
    output logic [7:0]           res_z,
    output logic [1:0]           res_nbytes,

    output logic                 sclk,
    output logic                 csn,
    output logic                 mosi,
    input  logic                 miso
);
    import spi_pkg::*;

    // decode to master
    logic       xfer_valid;
    logic       xfer_ready;
    spi_instr_t xfer_instr;
    logic [7:0] xfer_addr;
    logic [7:0] xfer_wdata;
    logic [1:0] xfer_nbytes;

    // master to pack
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_last;
    logic       rx_room;

    accel_cmd_decode dec0 (
        .iclk        (iclk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .cmd_ready   (cmd_ready),
        .xfer_valid  (xfer_valid),
        .xfer_ready  (xfer_ready),
        .xfer_instr  (xfer_instr),
        .xfer_addr   (xfer_addr),
        .xfer_wdata  (xfer_wdata),
        .xfer_nbytes (xfer_nbytes)
    );

    spi_master spi0 (
        .iclk        (iclk),
        .reset       (reset),
        .xfer_valid  (xfer_valid),
        .xfer_ready  (xfer_ready),
        .xfer_instr  (xfer_instr),
        .xfer_addr   (xfer_addr),
        .xfer_wdata  (xfer_wdata),
        .xfer_nbytes (xfer_nbytes),
        .rx_room     (rx_room),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_last     (rx_last),
        .sclk        (sclk),
        .csn         (csn),
        .mosi        (mosi),
        .miso        (miso)
    );

    accel_sample_pack pack0 (
        .iclk       (iclk),
        .reset      (reset),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_last    (rx_last),
        .rx_room    (rx_room),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_x      (res_x),
        .res_y      (res_y),
        .res_z      (res_z),
        .res_nbytes (res_nbytes)
    );

endmodule

//--- accel_sensor_model.sv
module accel_sensor_model (
    input  logic sclk,
    input  logic csn,
    input  logic mosi,
    output logic miso
);
    timeunit 1ns;
    timeprecision 1ps;
    import spi_pkg::*;

    logic [7:0] regs [0:63];    // sensor register file, filled by the testbench
    logic [7:0] in_sreg;
    logic [5:0] bit_cnt;        // bits since csn fell
    logic [7:0] instr;
    logic [5:0] addr;
    logic [5:0] data_bits;

    initial miso = 1'b0;

    // mosi sampled on the rising edge
    always @(posedge sclk or posedge csn) begin
        if (csn) begin
            bit_cnt <= '0;
        end else begin
            in_sreg <= {in_sreg[6:0], mosi};
            bit_cnt <= bit_cnt + 6'd1;
            if (bit_cnt == 6'd7) begin
                instr <= {in_sreg[6:0], mosi};
            end
            if (bit_cnt == 6'd15) begin
                addr <= {in_sreg[4:0], mosi};   // 64 registers, upper bits ignored
            end
            if (bit_cnt == 6'd23 && instr == instr_write) begin
                regs[addr] <= {in_sreg[6:0], mosi};
            end
        end
    end

    // read data shifts out on the falling edge, msb first
    always @(negedge sclk) begin
        if (!csn && instr == instr_read && bit_cnt >= 6'd16) begin
            data_bits = bit_cnt - 6'd16;
            miso <= regs[addr + data_bits[5:3]][~data_bits[2:0]];  // burst wraps at 64
        end
    end

endmodule

//--- accel_reader_checker.sv
`include "accel_consts.svh"

module accel_reader_checker (
    input logic                iclk,
    input logic                reset,
    input logic                csn,
    input logic                sclk,
    input logic                mosi,
    input spi_pkg::spi_instr_t xfer_instr,
    input logic                res_valid,
    input logic                res_ready,
    input logic [7:0]          res_x,
    input logic [7:0]          res_y,
    input logic [7:0]          res_z,
    input logic [1:0]          res_nbytes
);
    timeunit 1ns;
    timeprecision 1ps;
    import spi_pkg::*;

    int unsigned fail_cnt = 0;

    // pins quiet and no result while reset is held
    reset_quiet: assert property (@(posedge iclk)
        reset ##1 reset |-> csn && !sclk && !res_valid)
    else begin
        $error("spi pins or res_valid active during reset");
        fail_cnt++;
    end

    sclk_idle: assert property (@(posedge iclk) disable iff (reset) csn |-> !sclk)
    else begin
        $error("sclk high while csn is high");
        fail_cnt++;
    end

    cs_gap: assert property (@(posedge iclk) disable iff (reset)
        $rose(csn) |-> csn [* `CS_GAP])
    else begin
        $error("csn high time between frames too short");
        fail_cnt++;
    end

    mosi_hold: assert property (@(posedge iclk) disable iff (reset)
        sclk && $past(sclk) |-> $stable(mosi))
    else begin
        $error("mosi changed while sclk high");
        fail_cnt++;
    end

    // held result must not move until the host takes it
    res_hold: assert property (@(posedge iclk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable({res_x, res_y, res_z, res_nbytes}))
    else begin
        $error("result changed while waiting for res_ready");
        fail_cnt++;
    end

    // csn falling for a read frame needs the result register empty
    read_blocked: assert property (@(posedge iclk) disable iff (reset)
        $fell(csn) && xfer_instr == instr_read |-> !$past(res_valid))
    else begin
        $error("read frame started while a result was still held");
        fail_cnt++;
    end

endmodule

//--- tb_accel_reader.sv
`include "accel_consts.svh"

module tb_accel_reader;
    timeunit 1ns;
    timeprecision 1ps;
    import accel_pkg::*;

    localparam int WAIT_LIMIT = 4000;  // iclk cycles per wait

    logic       iclk;
    logic       reset;
    logic       cmd_valid;
    accel_op_t  cmd_op;
    logic [7:0] cmd_addr;
    logic [7:0] cmd_wdata;
    logic       cmd_ready;
    logic       res_valid;
    logic       res_ready;
    logic [7:0] res_x;
    logic [7:0] res_y;
    logic [7:0] res_z;
    logic [1:0] res_nbytes;
    logic       sclk;
    logic       csn;
    logic       mosi;
    logic       miso;

    logic [7:0]  mirror [0:63];     // expected sensor contents
    logic [31:0] rng;
    logic [5:0]  addr;
    logic [7:0]  data;
    int          errors = 0;
    int          timeouts = 0;
    bit          timed_out = 1'b0;

    accel_reader_top dut0 (.*);
    accel_sensor_model sensor0 (.sclk(sclk), .csn(csn), .mosi(mosi), .miso(miso));

    bind accel_reader_top accel_reader_checker chk0 (.*);

    always #20 iclk = ~iclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // wait at falling edges for cmd_ready or res_valid
    task automatic wait_until(input bit on_result);
        int n;
        if (timed_out) return;
        n = 0;
        @(negedge iclk);
        while (!(on_result ? res_valid : cmd_ready) && n < WAIT_LIMIT) begin
            @(negedge iclk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("timeout: DUT never raised %s", on_result ? "res_valid" : "cmd_ready");
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic send_cmd(input accel_op_t op, input logic [7:0] a, input logic [7:0] d);
        if (timed_out) return;
        @(posedge iclk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_addr  <= a;
        cmd_wdata <= d;
        wait_until(1'b0);
        @(posedge iclk);            // transfer edge
        cmd_valid <= 1'b0;
    endtask

    task automatic take_result();
        if (timed_out) return;
        @(posedge iclk);
        res_ready <= 1'b1;
        @(posedge iclk);
        res_ready <= 1'b0;
    endtask

    task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (timed_out) return;
        assert (act === exp) else begin
            $display("FAIL %0t %s expected %02h got %02h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_result(input logic [7:0] ex, input logic [7:0] ey,
                                input logic [7:0] ez, input logic [1:0] en);
        check_val("res_x", ex, res_x);
        check_val("res_y", ey, res_y);
        check_val("res_z", ez, res_z);
        check_val("res_nbytes", {6'd0, en}, {6'd0, res_nbytes});
    endtask

    initial begin
        iclk      = 1'b0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = op_read_xyz;
        cmd_addr  = 8'h00;
        cmd_wdata = 8'h00;
        res_ready = 1'b0;
        rng       = 32'd6350;
        for (int i = 0; i < 64; i++) begin
            rng = xorshift32(rng);
            sensor0.regs[i] = rng[7:0];
            mirror[i] = rng[7:0];
        end
        repeat (8) @(posedge iclk);
        reset <= 1'b0;

        // burst read queued during sensor start-up, csn must wait
        fork
            send_cmd(op_read_xyz, 8'h00, 8'h00);
            repeat (`POWERUP_CYCLES) begin
                @(negedge iclk);
                check_val("csn", 8'h01, {7'd0, csn});
            end
        join
        wait_until(1'b1);
        check_result(mirror[`XDATA_ADDR], mirror[`XDATA_ADDR + 1], mirror[`XDATA_ADDR + 2], 2'd3);
        take_result();

        // write then read back
        rng = xorshift32(rng);
        addr = rng[5:0];
        data = rng[15:8];
        send_cmd(op_write_reg, {2'b00, addr}, data);
        mirror[addr] = data;
        send_cmd(op_read_reg, {2'b00, addr}, 8'h00);
        wait_until(1'b1);
        check_result(mirror[addr], 8'h00, 8'h00, 2'd1);
        take_result();

        // host stalls, pending write still runs and the read queues
        send_cmd(op_read_xyz, 8'h00, 8'h00);
        wait_until(1'b1);
        check_result(mirror[`XDATA_ADDR], mirror[`XDATA_ADDR + 1], mirror[`XDATA_ADDR + 2], 2'd3);
        rng = xorshift32(rng);
        addr = rng[5:0];
        data = rng[15:8];
        send_cmd(op_write_reg, {2'b00, addr}, data);
        mirror[addr] = data;
        send_cmd(op_read_reg, {2'b00, addr}, 8'h00);
        rng = xorshift32(rng);
        repeat (120 + rng[6:0]) @(posedge iclk);
        take_result();
        wait_until(1'b1);
        check_result(mirror[addr], 8'h00, 8'h00, 2'd1);
        take_result();

        @(negedge iclk);
        $display("errors: %0d value, %0d timeout, %0d assertion",
                 errors, timeouts, dut0.chk0.fail_cnt);
        if (errors == 0 && timeouts == 0 && dut0.chk0.fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
spi_pkg.sv
accel_pkg.sv
accel_cmd_decode.sv
spi_master.sv
accel_sample_pack.sv
accel_reader_top.sv
accel_sensor_model.sv
accel_reader_checker.sv
tb_accel_reader.sv

//--- Bender.yml
package:
  name: accel_reader

export_include_dirs:
  - .

sources:
  - spi_pkg.sv
  - accel_pkg.sv
  - accel_cmd_decode.sv
  - spi_master.sv
  - accel_sample_pack.sv
  - accel_reader_top.sv
  - target: test
    files:
      - accel_sensor_model.sv
      - accel_reader_checker.sv
      - tb_accel_reader.sv
